//--- logic/apb_win_pkg.sv
package apb_win_pkg;

	localparam int DATA_W = 32;                      // APB data bus width.
	localparam int STRB_W = DATA_W / 8;              // One write strobe per data byte.

	typedef logic [DATA_W-1:0] reg_data_t;
	typedef logic [STRB_W-1:0] reg_strb_t;
	typedef logic [2:0]        reg_sel_t;            // Word index taken from paddr bits 4:2.
	typedef logic [15:0]       win_addr_t;           // Address on the monitored bus.
	typedef logic [7:0]        hit_cnt_t;            // Saturating hit counter.

	localparam int NUM_WINDOWS = 4;

	// Register word indices.
	localparam reg_sel_t REG_CONTROL = 3'd0;
	localparam reg_sel_t REG_WIN0    = 3'd1;
	localparam reg_sel_t REG_WIN1    = 3'd2;
	localparam reg_sel_t REG_WIN2    = 3'd3;
	localparam reg_sel_t REG_WIN3    = 3'd4;
	localparam reg_sel_t REG_STATUS  = 3'd5;

	// Control register. Bits 3:0 enable windows 0 to 3.
	localparam int CTRL_WIN_EN_LSB = 0;
	localparam int CTRL_CLR_BIT    = 8;              // Write one to clear status.
	localparam int CTRL_IRQ_EN_BIT = 12;

	// A window word holds the base in the upper half and the mask in the lower half.
	localparam int WIN_BASE_LSB = 16;
	localparam int WIN_MASK_LSB = 0;

	// Status register layout. Bits 3:0 are the sticky window hits.
	localparam int STAT_HIT_LSB  = 0;
	localparam int STAT_MISS_BIT = 4;
	localparam int STAT_CNT_LSB  = 16;

endpackage

//--- logic/apb_reg_if.sv
`timescale 1ns/1ps

module apb_reg_if #(
	parameter int g_apb_addr_width = 8
) (
	input  logic                       pclk_i,
	input  logic                       preset_n_i,
	input  logic [g_apb_addr_width-1:0] paddr_i,
	input  logic [2:0]                 pprot_i,          // Protection type, not decoded.
	input  logic                       psel_i,
	input  logic                       penable_i,
	input  logic                       pwrite_i,
	input  apb_win_pkg::reg_data_t     pwdata_i,
	input  apb_win_pkg::reg_strb_t     pstrb_i,
	output logic                       pready_o,
	output apb_win_pkg::reg_data_t     prdata_o,
	output logic                       pslverr_o,
	input  apb_win_pkg::reg_data_t     reg_ctrl_i,
	input  apb_win_pkg::reg_data_t     reg_win0_i,
	input  apb_win_pkg::reg_data_t     reg_win1_i,
	input  apb_win_pkg::reg_data_t     reg_win2_i,
	input  apb_win_pkg::reg_data_t     reg_win3_i,
	input  apb_win_pkg::reg_data_t     reg_status_i,
	output apb_win_pkg::reg_data_t     reg_data_o,
	output apb_win_pkg::reg_strb_t     reg_strb_o,
	output logic                       reg_load_o,
	output apb_win_pkg::reg_sel_t      reg_sel_o
);
	import apb_win_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ACCESS,
		RESPOND
	} apb_state_t;

	apb_state_t state_q;
	apb_state_t state_d;
	logic       setup;
	logic       wr_q;
	logic       upper_ok_q;
	reg_sel_t   sel_q;
	reg_data_t  wdata_q;
	reg_strb_t  strb_q;
	reg_data_t  rd_mux;
	logic       rd_legal;
	logic       wr_legal;
	logic       pready_q;
	logic       pslverr_q;
	logic       reg_load_q;
	reg_data_t  prdata_q;

	assign setup = psel_i && !penable_i;                // First cycle of a transfer.

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:    if (setup) state_d = ACCESS;
			ACCESS:  state_d = RESPOND;                 // Single wait state, penable is not checked.
			RESPOND: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge pclk_i or negedge preset_n_i)
	begin
		if (!preset_n_i)
		begin
			state_q    <= IDLE;
			wr_q       <= 1'b0;
			upper_ok_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			if (state_q == IDLE && setup)
			begin
				wr_q       <= pwrite_i;
				upper_ok_q <= (paddr_i >> 5) == '0;  // Only word indices 0 to 7 exist.
			end
		end
	end

	// Address and write payload are held for the whole transfer.
	always_ff @(posedge pclk_i)
	begin
		if (state_q == IDLE && setup)
		begin
			sel_q   <= paddr_i[4:2];
			wdata_q <= pwdata_i;
			strb_q  <= pstrb_i;
		end
	end

	assign rd_legal = upper_ok_q && (sel_q <= REG_STATUS);
	assign wr_legal = upper_ok_q && (sel_q < REG_STATUS);  // Status is read only.

	always_comb
	begin
		case (sel_q)
			REG_CONTROL: rd_mux = reg_ctrl_i;
			REG_WIN0:    rd_mux = reg_win0_i;
			REG_WIN1:    rd_mux = reg_win1_i;
			REG_WIN2:    rd_mux = reg_win2_i;
			REG_WIN3:    rd_mux = reg_win3_i;
			REG_STATUS:  rd_mux = reg_status_i;
			default:     rd_mux = '0;
		endcase
	end

	// Response outputs are set on entry to RESPOND and drop again after one cycle.
	always_ff @(posedge pclk_i or negedge preset_n_i)
	begin
		if (!preset_n_i)
		begin
			pready_q   <= 1'b0;
			pslverr_q  <= 1'b0;
			reg_load_q <= 1'b0;
			prdata_q   <= '0;
		end
		else if (state_q == ACCESS)
		begin
			pready_q   <= 1'b1;
			pslverr_q  <= wr_q ? !wr_legal : !rd_legal;
			reg_load_q <= wr_q && wr_legal;
			prdata_q   <= (!wr_q && rd_legal) ? rd_mux : '0;
		end
		else
		begin
			pready_q   <= 1'b0;
			pslverr_q  <= 1'b0;
			reg_load_q <= 1'b0;
			prdata_q   <= '0;
		end
	end

	assign pready_o   = pready_q;
	assign pslverr_o  = pslverr_q;
	assign prdata_o   = prdata_q;
	assign reg_load_o = reg_load_q;
	assign reg_sel_o  = sel_q;
	assign reg_data_o = wdata_q;
	assign reg_strb_o = strb_q;

endmodule

//--- logic/win_reg_bank.sv
`timescale 1ns/1ps

module win_reg_bank (
	input  logic                   pclk_i,
	input  logic                   preset_n_i,
	input  apb_win_pkg::reg_sel_t  reg_sel_i,
	input  apb_win_pkg::reg_data_t reg_data_i,
	input  apb_win_pkg::reg_strb_t reg_strb_i,
	input  logic                   reg_load_i,
	output apb_win_pkg::reg_data_t ctrl_o,
	output apb_win_pkg::reg_data_t win0_o,
	output apb_win_pkg::reg_data_t win1_o,
	output apb_win_pkg::reg_data_t win2_o,
	output apb_win_pkg::reg_data_t win3_o,
	output logic                   status_clr_o
);
	import apb_win_pkg::*;

	reg_data_t ctrl_q;
	reg_data_t win_q [NUM_WINDOWS];
	reg_data_t ctrl_next;
	logic      clr_req;
	logic      status_clr_q;

	// Bytes with a strobe take the new data, the rest keep their value.
	function automatic reg_data_t byte_merge(input reg_data_t old_val,
	                                         input reg_data_t new_val,
	                                         input reg_strb_t strb);
		reg_data_t result;
		result = old_val;
		for (int b = 0; b < STRB_W; b++)
		begin
			if (strb[b])
				result[b*8 +: 8] = new_val[b*8 +: 8];
		end
		return result;
	endfunction

	always_comb
	begin
		ctrl_next               = byte_merge(ctrl_q, reg_data_i, reg_strb_i);
		ctrl_next[CTRL_CLR_BIT] = 1'b0;                // The clear bit is a command only.
	end

	assign clr_req = reg_strb_i[CTRL_CLR_BIT/8] && reg_data_i[CTRL_CLR_BIT];

	always_ff @(posedge pclk_i or negedge preset_n_i)
	begin
		if (!preset_n_i)
		begin
			ctrl_q       <= '0;
			status_clr_q <= 1'b0;
			for (int i = 0; i < NUM_WINDOWS; i++)
				win_q[i] <= '0;
		end
		else
		begin
			status_clr_q <= 1'b0;
			if (reg_load_i)
			begin
				if (reg_sel_i == REG_CONTROL)
				begin
					ctrl_q       <= ctrl_next;
					status_clr_q <= clr_req;
				end
				for (int i = 0; i < NUM_WINDOWS; i++)
				begin
					if (reg_sel_i == reg_sel_t'(REG_WIN0 + i))
						win_q[i] <= byte_merge(win_q[i], reg_data_i, reg_strb_i);
				end
			end
		end
	end

	assign ctrl_o       = ctrl_q;
	assign win0_o       = win_q[0];
	assign win1_o       = win_q[1];
	assign win2_o       = win_q[2];
	assign win3_o       = win_q[3];
	assign status_clr_o = status_clr_q;

endmodule

//--- logic/addr_window_match.sv
`timescale 1ns/1ps

module addr_window_match (
	input  logic                   pclk_i,
	input  logic                   preset_n_i,
	input  logic                   mon_valid_i,
	input  apb_win_pkg::win_addr_t mon_addr_i,
	input  apb_win_pkg::reg_data_t ctrl_i,
	input  apb_win_pkg::reg_data_t win0_i,
	input  apb_win_pkg::reg_data_t win1_i,
	input  apb_win_pkg::reg_data_t win2_i,
	input  apb_win_pkg::reg_data_t win3_i,
	input  logic                   status_clr_i,
	output apb_win_pkg::reg_data_t status_o
);
	import apb_win_pkg::*;

	reg_data_t              win_w [NUM_WINDOWS];
	logic [NUM_WINDOWS-1:0] win_en;
	logic [NUM_WINDOWS-1:0] hit_vec;
	logic [NUM_WINDOWS-1:0] sticky_q;
	logic                   miss_q;
	hit_cnt_t               hit_cnt_q;
	reg_data_t              status;

	assign win_w  = '{win0_i, win1_i, win2_i, win3_i};
	assign win_en = ctrl_i[CTRL_WIN_EN_LSB +: NUM_WINDOWS];

	always_comb
	begin
		for (int i = 0; i < NUM_WINDOWS; i++)
		begin
			win_addr_t base;
			win_addr_t mask;
			base       = win_w[i][WIN_BASE_LSB +: $bits(win_addr_t)];
			mask       = win_w[i][WIN_MASK_LSB +: $bits(win_addr_t)];
			hit_vec[i] = win_en[i] && ((mon_addr_i & mask) == (base & mask));
		end
	end

	always_ff @(posedge pclk_i or negedge preset_n_i)
	begin
		if (!preset_n_i)
		begin
			sticky_q  <= '0;
			miss_q    <= 1'b0;
			hit_cnt_q <= '0;
		end
		else if (status_clr_i)
		begin
			sticky_q  <= '0;                            // Clear takes priority over a new hit.
			miss_q    <= 1'b0;
			hit_cnt_q <= '0;
		end
		else if (mon_valid_i)
		begin
			sticky_q <= sticky_q | hit_vec;
			if (hit_vec == '0)
				miss_q <= 1'b1;
			else if (hit_cnt_q != '1)
				hit_cnt_q <= hit_cnt_q + 1'b1;          // Holds at 255.
		end
	end

	always_comb
	begin
		status                                        = '0;
		status[STAT_HIT_LSB +: NUM_WINDOWS]           = sticky_q;
		status[STAT_MISS_BIT]                         = miss_q;
		status[STAT_CNT_LSB +: $bits(hit_cnt_t)]      = hit_cnt_q;
	end

	assign status_o = status;

endmodule

//--- logic/apb_win_top.sv
`timescale 1ns/1ps

module apb_win_top #(
	parameter int g_apb_addr_width = 8
) (
	input  logic                        pclk_i,
	input  logic                        preset_n_i,
	input  logic [g_apb_addr_width-1:0] paddr_i,
	input  logic [2:0]                  pprot_i,
	input  logic                        psel_i,
	input  logic                        penable_i,
	input  logic                        pwrite_i,
	input  apb_win_pkg::reg_data_t      pwdata_i,
	input  apb_win_pkg::reg_strb_t      pstrb_i,
	output logic                        pready_o,
	output apb_win_pkg::reg_data_t      prdata_o,
	output logic                        pslverr_o,
	input  logic                        mon_valid_i,
	input  apb_win_pkg::win_addr_t      mon_addr_i,
	output logic                        irq_o
);
	import apb_win_pkg::*;

	reg_sel_t  reg_sel;
	reg_data_t reg_data;
	reg_strb_t reg_strb;
	logic      reg_load;
	reg_data_t ctrl;
	reg_data_t win0;
	reg_data_t win1;
	reg_data_t win2;
	reg_data_t win3;
	reg_data_t status;
	logic      status_clr;

	apb_reg_if #(
		.g_apb_addr_width (g_apb_addr_width)
	) apb_reg_if_inst (
		.pclk_i       (pclk_i),
		.preset_n_i   (preset_n_i),
		.paddr_i      (paddr_i),
		.pprot_i      (pprot_i),
		.psel_i       (psel_i),
		.penable_i    (penable_i),
		.pwrite_i     (pwrite_i),
		.pwdata_i     (pwdata_i),
		.pstrb_i      (pstrb_i),
		.pready_o     (pready_o),
		.prdata_o     (prdata_o),
		.pslverr_o    (pslverr_o),
		.reg_ctrl_i   (ctrl),
		.reg_win0_i   (win0),
		.reg_win1_i   (win1),
		.reg_win2_i   (win2),
		.reg_win3_i   (win3),
		.reg_status_i (status),
		.reg_data_o   (reg_data),
		.reg_strb_o   (reg_strb),
		.reg_load_o   (reg_load),
		.reg_sel_o    (reg_sel)
	);

	win_reg_bank win_reg_bank_inst (
		.pclk_i       (pclk_i),
		.preset_n_i   (preset_n_i),
		.reg_sel_i    (reg_sel),
		.reg_data_i   (reg_data),
		.reg_strb_i   (reg_strb),
		.reg_load_i   (reg_load),
		.ctrl_o       (ctrl),
		.win0_o       (win0),
		.win1_o       (win1),
		.win2_o       (win2),
		.win3_o       (win3),
		.status_clr_o (status_clr)
	);

	addr_window_match addr_window_match_inst (
		.pclk_i       (pclk_i),
		.preset_n_i   (preset_n_i),
		.mon_valid_i  (mon_valid_i),
		.mon_addr_i   (mon_addr_i),
		.ctrl_i       (ctrl),
		.win0_i       (win0),
		.win1_i       (win1),
		.win2_i       (win2),
		.win3_i       (win3),
		.status_clr_i (status_clr),
		.status_o     (status)
	);

	// Any sticky hit or the miss flag raises the interrupt when enabled.
	assign irq_o = ctrl[CTRL_IRQ_EN_BIT] && (|status[STAT_MISS_BIT:STAT_HIT_LSB]);

endmodule

//--- verification/apb_win_sva.sv
`timescale 1ns/1ps

module apb_win_sva (
	input logic pclk_i,
	input logic preset_n_i,
	input logic psel_i,
	input logic penable_i,
	input logic pready_o,
	input logic pslverr_o,
	input logic reg_load_o
);

	// One wait state, so the response is seen on the second edge after the sampled setup.
	property p_ready_timing;
		@(posedge pclk_i) disable iff (!preset_n_i)
			(psel_i && !penable_i && !pready_o) |-> ##1 !pready_o ##1 pready_o;
	endproperty

	a_ready_timing: assert property (p_ready_timing)
		else $error("pready_o did not rise two cycles after the setup phase");

	a_load_no_err: assert property (@(posedge pclk_i) disable iff (!preset_n_i)
		!(reg_load_o && pslverr_o))
		else $error("reg_load_o and pslverr_o are high together");

	a_reset_ready: assert property (@(posedge pclk_i) !preset_n_i |-> !pready_o)
		else $error("pready_o is high during reset");

endmodule

bind apb_reg_if apb_win_sva apb_win_sva_inst (
	.pclk_i     (pclk_i),
	.preset_n_i (preset_n_i),
	.psel_i     (psel_i),
	.penable_i  (penable_i),
	.pready_o   (pready_o),
	.pslverr_o  (pslverr_o),
	.reg_load_o (reg_load_o)
);

//--- verification/apb_win_tb.sv
`timescale 1ns/1ps

module apb_win_tb;
	import apb_win_pkg::*;

	localparam int ADDR_W     = 8;
	localparam int MAX_CYCLES = 3000;                 // About 1000 cycles of traffic, with margin.

	logic              pclk;
	logic              preset_n;
	logic [ADDR_W-1:0] paddr;
	logic [2:0]        pprot;
	logic              psel;
	logic              penable;
	logic              pwrite;
	reg_data_t         pwdata;
	reg_strb_t         pstrb;
	logic              pready;
	reg_data_t         prdata;
	logic              pslverr;
	logic              mon_valid;
	win_addr_t         mon_addr;
	logic              irq;

	int          errors;
	int          checks;
	int          cycles = 0;
	logic [31:0] rng;
	reg_data_t   model [5];                            // Control and the four windows.
	logic [3:0]  exp_sticky;
	logic        exp_miss;
	logic [7:0]  exp_cnt;

	apb_win_top #(
		.g_apb_addr_width (ADDR_W)
	) apb_win_top_inst (
		.pclk_i      (pclk),
		.preset_n_i  (preset_n),
		.paddr_i     (paddr),
		.pprot_i     (pprot),
		.psel_i      (psel),
		.penable_i   (penable),
		.pwrite_i    (pwrite),
		.pwdata_i    (pwdata),
		.pstrb_i     (pstrb),
		.pready_o    (pready),
		.prdata_o    (prdata),
		.pslverr_o   (pslverr),
		.mon_valid_i (mon_valid),
		.mon_addr_i  (mon_addr),
		.irq_o       (irq)
	);

	always #50 pclk = ~pclk;

	always @(posedge pclk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic reg_data_t strobe_merge(input reg_data_t old_val, input reg_data_t new_val,
	                                           input reg_strb_t strb);
		reg_data_t keep;
		keep = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_val & ~keep) | (new_val & keep);
	endfunction

	function automatic reg_data_t exp_status();
		return {8'h00, exp_cnt, 11'h000, exp_miss, exp_sticky};
	endfunction

	function automatic reg_data_t exp_irq();
		return 32'(model[0][CTRL_IRQ_EN_BIT] && (exp_sticky != 4'h0 || exp_miss));
	endfunction

	task check_val(input string name, input reg_data_t got, input reg_data_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// Setup on one falling edge, access on the next, then wait for pready.
	task apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr, input reg_data_t data,
	                  input reg_strb_t strb, output reg_data_t rdata, output logic err);
		int waited;
		@(negedge pclk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = data;
		pstrb   = strb;
		@(negedge pclk);
		penable = 1'b1;
		waited  = 0;
		while (!pready && waited < 8)
		begin
			@(negedge pclk);
			waited++;
		end
		if (!pready)
		begin
			$display("No pready_o response for address 0x%h", addr);
			errors++;
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge pclk);                                 // Transfer completes on the edge before.
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task apb_write(input logic [ADDR_W-1:0] addr, input reg_data_t data, input reg_strb_t strb,
	               output logic err);
		reg_data_t unused;
		apb_transfer(1'b1, addr, data, strb, unused, err);
	endtask

	task apb_read(input logic [ADDR_W-1:0] addr, output reg_data_t data, output logic err);
		apb_transfer(1'b0, addr, 32'h0, 4'h0, data, err);
	endtask

	task model_write(input int idx, input reg_data_t data, input reg_strb_t strb);
		logic err;
		apb_write(ADDR_W'(idx * 4), data, strb, err);
		check_val("pslverr_o", 32'(err), 32'h0);
		model[idx] = strobe_merge(model[idx], data, strb);
		if (idx == 0)
		begin
			model[0][CTRL_CLR_BIT] = 1'b0;             // Clear is a command and is never stored.
			if (strb[CTRL_CLR_BIT / 8] && data[CTRL_CLR_BIT])
			begin
				exp_sticky = 4'h0;
				exp_miss   = 1'b0;
				exp_cnt    = 8'h00;
			end
		end
	endtask

	task check_regs();
		reg_data_t rdata;
		logic      err;
		for (int i = 0; i < 6; i++)
		begin
			apb_read(ADDR_W'(i * 4), rdata, err);
			check_val($sformatf("pslverr_o reg %0d", i), 32'(err), 32'h0);
			if (i < 5)
				check_val($sformatf("prdata_o reg %0d", i), rdata, model[i]);
			else
				check_val("prdata_o status", rdata, exp_status());
		end
	endtask

	// One monitored address, with the expected status updated by the window rule.
	task send_mon(input win_addr_t addr);
		logic [3:0] hits;
		hits = 4'h0;
		for (int i = 0; i < 4; i++)
		begin
			if (model[0][i] && (((addr ^ model[i + 1][31:16]) & model[i + 1][15:0]) == 16'h0))
				hits[i] = 1'b1;
		end
		exp_sticky = exp_sticky | hits;
		if (hits == 4'h0)
			exp_miss = 1'b1;
		else if (exp_cnt != 8'hFF)
			exp_cnt = exp_cnt + 8'd1;
		@(negedge pclk);
		mon_valid = 1'b1;
		mon_addr  = addr;
		@(negedge pclk);
		mon_valid = 1'b0;
	endtask

	task check_irq();
		@(negedge pclk);                                 // Lets a pending status clear land.
		check_val("irq_o", 32'(irq), exp_irq());
	endtask

	task test_reset_values();
		check_val("irq_o", 32'(irq), 32'h0);
		check_regs();
	endtask

	task test_random_writes();
		int        idx;
		reg_data_t data;
		reg_data_t rdata;
		logic      err;
		repeat (24)
		begin
			rng  = xorshift32(rng);
			idx  = int'(rng % 5);
			rng  = xorshift32(rng);
			data = rng;
			rng  = xorshift32(rng);
			model_write(idx, data, rng[3:0]);
			apb_read(ADDR_W'(idx * 4), rdata, err);
			check_val("prdata_o", rdata, model[idx]);
		end
		check_regs();
	endtask

	task test_bad_access();
		logic [ADDR_W-1:0] bad_rd [4];
		logic [ADDR_W-1:0] bad_wr [5];
		reg_data_t         rdata;
		logic              err;
		bad_rd = '{8'h18, 8'h1C, 8'h20, 8'hA4};
		bad_wr = '{8'h14, 8'h18, 8'h1C, 8'h40, 8'hE0};
		foreach (bad_rd[i])
		begin
			apb_read(bad_rd[i], rdata, err);
			check_val("pslverr_o", 32'(err), 32'h1);
			check_val("prdata_o", rdata, 32'h0);
		end
		foreach (bad_wr[i])
		begin
			apb_write(bad_wr[i], 32'hFFFF_FFFF, 4'hF, err);
			check_val("pslverr_o", 32'(err), 32'h1);
		end
		check_regs();
	endtask

	task test_window_match();
		win_addr_t addrs [6];
		addrs = '{16'h1234, 16'h2099, 16'h0045, 16'hABCD, 16'h5555, 16'h1F4F};
		model_write(1, {16'h1000, 16'hF000}, 4'hF);
		model_write(2, {16'h2000, 16'hFF00}, 4'hF);
		model_write(3, {16'h0040, 16'h00F0}, 4'hF);
		model_write(4, {16'hABCD, 16'hFFFF}, 4'hF);
		model_write(0, 32'h0000_0107, 4'hF);          // Window 3 stays disabled for now.
		foreach (addrs[i])
			send_mon(addrs[i]);
		check_regs();
		model_write(0, 32'h0000_000F, 4'h1);
		send_mon(16'hABCD);
		repeat (280)
		begin
			rng = xorshift32(rng);
			send_mon({4'h1, rng[11:0]});
		end
		check_regs();
	endtask

	task test_clear_irq();
		check_val("irq_o", 32'(irq), exp_irq());
		model_write(0, 32'h0000_100F, 4'hF);
		check_irq();
		model_write(0, 32'h0000_110F, 4'hF);
		check_irq();
		check_regs();
		send_mon(16'h5555);
		check_irq();
		model_write(0, 32'h0000_000F, 4'h2);          // Drops only the interrupt enable.
		check_irq();
		check_regs();
	endtask

	initial
	begin
		pclk       = 1'b0;
		preset_n   = 1'b0;
		paddr      = '0;
		pprot      = 3'b000;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		pwdata     = '0;
		pstrb      = '0;
		mon_valid  = 1'b0;
		mon_addr   = '0;
		errors     = 0;
		checks     = 0;
		rng        = 32'd15;
		exp_sticky = 4'h0;
		exp_miss   = 1'b0;
		exp_cnt    = 8'h00;
		foreach (model[i])
			model[i] = '0;
		repeat (8) @(negedge pclk);
		preset_n = 1'b1;
		test_reset_values();
		test_random_writes();
		test_bad_access();
		test_window_match();
		test_clear_irq();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- sim.f
logic/apb_win_pkg.sv
logic/apb_reg_if.sv
logic/win_reg_bank.sv
logic/addr_window_match.sv
logic/apb_win_top.sv
verification/apb_win_sva.sv
verification/apb_win_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module apb_win_tb -f sim.f -o sim_apb_win

sim_out=$(./obj_dir/sim_apb_win)
echo "$sim_out"

if echo "$sim_out" | grep -q "Simulation passed"; then
	exit 0
fi
exit 1
